/* verilog.f */
fix_pkg.sv
fix_lexer.sv
fix_field_extract.sv
fix_field_fifo.sv
fix_parser_top.sv
fix_parser_assert.sv
tb_fix_parser.sv

/* Makefile */
# Verilator build and run of the FIX field parser testbench.

VERILATOR ?= verilator
TOP       ?= tb_fix_parser
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "result: failure found in $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "result: run ended without a result in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_fix_parser.sv */
// ######################################################################
// testbench of the FIX field parser, default parameters only.
// expected records follow the field rules with FIELD_VALUE_BYTES as the
// value limit. a field table entry without SOH must be the last one.
// ######################################################################

`timescale 1ns/1ns

module tb_fix_parser import fix_pkg::*; ();

	localparam int MAX_VAL       = FIELD_VALUE_BYTES;
	localparam int BYTE_TIMEOUT  = 200; // cycles to get one byte accepted.
	localparam int DRAIN_TIMEOUT = 800; // cycles for a test's records to come out.
	localparam int NUM_TESTS     = 5;

	logic       clk = 1'b0;
	logic       rst;
	logic [7:0] in_data_i;
	logic       in_valid_i;
	logic       in_ready_o;
	fix_field_t field_o;
	logic       field_valid_o;
	logic       field_ready_i;

	// field table, one entry per FIX field.
	int         tab_test[$];
	string      tab_tag[$];
	string      tab_val[$];
	bit         tab_soh[$];
	bit         tab_eq[$];
	logic [3:0] tab_flags[$]; // {start, end, overflow, malformed}.
	string      test_name[1:NUM_TESTS];

	fix_field_t  exp_q[$];
	logic [31:0] lfsr = 32'h80bf_03f6;
	bit          rand_mode = 1'b0;
	bit          timed_out = 1'b0;
	int          errors = 0;
	int          test_errors = 0;
	int          received = 0;
	int          tests_run = 0;
	int          tests_passed = 0;

	fix_parser_top dut (
		.clk           (clk),
		.rst           (rst),
		.in_data_i     (in_data_i),
		.in_valid_i    (in_valid_i),
		.in_ready_o    (in_ready_o),
		.field_o       (field_o),
		.field_valid_o (field_valid_o),
		.field_ready_i (field_ready_i)
	);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1, new bit shifted in at the bottom.
	function automatic logic take_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	task automatic add_entry(input int t, input string tag, input string val,
			input bit soh, input bit eq, input logic [3:0] flags);
		tab_test.push_back(t);
		tab_tag.push_back(tag);
		tab_val.push_back(val);
		tab_soh.push_back(soh);
		tab_eq.push_back(eq);
		tab_flags.push_back(flags);
	endtask

	task automatic fill_table();
		test_name[1] = "complete message";
		test_name[2] = "truncation";
		test_name[3] = "malformed field";
		test_name[4] = "random back-pressure";
		test_name[5] = "empty value";
		// test, tag, value, SOH, '=', flags {start, end, overflow, malformed}.
		add_entry(1, "8", "FIX.4.2", 1, 1, 4'b1000);
		add_entry(1, "9", "12", 1, 1, 4'b0000);
		add_entry(1, "35", "D", 1, 1, 4'b0000);
		add_entry(1, "10", "123", 1, 1, 4'b0100);
		add_entry(2, "58", "THIS VALUE IS TOO LONG", 1, 1, 4'b0010);
		add_entry(2, "12345", "X", 1, 1, 4'b0010);
		add_entry(2, "95", "ABCDEFGHIJKLMNOP", 1, 1, 4'b0000);
		add_entry(2, "123456", "0123456789ABCDEFGHIJ", 1, 1, 4'b0010);
		add_entry(3, "35D", "", 1, 0, 4'b0001);
		add_entry(3, "49", "SENDER", 1, 1, 4'b0000);
		add_entry(3, "ABCDEFG", "", 1, 0, 4'b0011);
		add_entry(3, "56", "TARGET", 1, 1, 4'b0000);
		add_entry(4, "8", "FIX.4.4", 1, 1, 4'b1000);
		add_entry(4, "9", "40", 1, 1, 4'b0000);
		add_entry(4, "35", "8", 1, 1, 4'b0000);
		add_entry(4, "55", "A=B", 1, 1, 4'b0000);
		add_entry(4, "58X", "", 1, 0, 4'b0001);
		add_entry(4, "96", "LONG RAW DATA BLOCK", 1, 1, 4'b0010);
		add_entry(4, "44", "101.25", 1, 1, 4'b0000);
		add_entry(4, "10", "200", 1, 1, 4'b0100);
		add_entry(5, "58", "", 1, 1, 4'b0000);
		add_entry(5, "8", "", 1, 1, 4'b1000);
		add_entry(5, "10", "", 1, 1, 4'b0100);
		add_entry(5, "11", "OPEN", 0, 1, 4'b0000); // never closed, no record.
	endtask

	// without '=' every byte up to SOH counts as a tag byte.
	function automatic fix_field_t expected_record(input string tag, input string val,
			input bit eq, input logic [3:0] flags);
		fix_field_t r;
		string      tag_bytes;
		r = '0;
		tag_bytes = eq ? tag : {tag, val};
		for (int i = 0; i < tag_bytes.len() && i < 4; i++) begin
			r.tag = {r.tag[23:0], tag_bytes[i]};
		end
		if (eq) begin
			for (int i = 0; i < val.len() && i < MAX_VAL; i++) begin
				r.value = (r.value << 8) | val[i];
			end
			r.value_len = (val.len() > 255) ? 8'hff : 8'(val.len());
		end
		{r.start_of_message, r.end_of_message, r.overflow, r.malformed} = flags;
		return r;
	endfunction

	// next edge, then the output ready for the coming cycle.
	task automatic tick();
		logic b0;
		logic b1;
		@(posedge clk);
		#1;
		if (rand_mode) begin
			b0 = take_bit();
			b1 = take_bit();
			field_ready_i = !(b0 && b1);
		end else begin
			field_ready_i = 1'b1;
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		int gaps;
		int waited;
		bit took;
		gaps = 0;
		while (rand_mode && gaps < 4 && take_bit() && take_bit()) begin
			in_valid_i = 1'b0;
			tick();
			gaps++;
		end
		in_data_i  = b;
		in_valid_i = 1'b1;
		waited     = 0;
		took       = 1'b0;
		while (!took && waited < BYTE_TIMEOUT) begin
			@(negedge clk);
			took = in_ready_o; // the byte moves at the next edge.
			tick();
			waited++;
		end
		in_valid_i = 1'b0;
		if (!took) begin
			$display("timeout: input byte %h not accepted at %0t", b, $time);
			timed_out = 1'b1;
		end
	endtask

	task automatic send_field(input int k);
		if (tab_soh[k]) begin
			exp_q.push_back(expected_record(tab_tag[k], tab_val[k], tab_eq[k], tab_flags[k]));
		end
		for (int i = 0; i < tab_tag[k].len() && !timed_out; i++) begin
			send_byte(tab_tag[k][i]);
		end
		if (tab_eq[k] && !timed_out) begin
			send_byte(FIX_EQ);
		end
		for (int i = 0; i < tab_val[k].len() && !timed_out; i++) begin
			send_byte(tab_val[k][i]);
		end
		if (tab_soh[k] && !timed_out) begin
			send_byte(FIX_SOH);
		end
	endtask

	task automatic run_test(input int t);
		int reps;
		int waited;
		test_errors = 0;
		rand_mode   = (t == 4);
		reps        = (t == 4) ? 12 : 1;
		for (int r = 0; r < reps && !timed_out; r++) begin
			for (int k = 0; k < tab_test.size() && !timed_out; k++) begin
				if (tab_test[k] == t) begin
					send_field(k);
				end
			end
		end
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
			tick();
			waited++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d records of test %0d never came out", exp_q.size(), t);
			timed_out = 1'b1;
		end
		rand_mode = 1'b0;
		tests_run++;
		if (test_errors == 0 && !timed_out) begin
			tests_passed++;
			$display("test %0d %s: ok", t, test_name[t]);
		end else begin
			$display("test %0d %s: %0d errors", t, test_name[t], test_errors);
		end
	endtask

	// valid and ready are stable mid-cycle, the record moves at the next edge.
	always @(negedge clk) begin
		fix_field_t e;
		if (!rst && field_valid_o && field_ready_i) begin
			if (exp_q.size() == 0) begin
				$display("FAILED %0t: unexpected record, tag %h", $time, field_o.tag);
				errors++;
				test_errors++;
			end else begin
				e = exp_q.pop_front();
				if (field_o !== e) begin
					$display("FAILED %0t: record %0d tag %h len %0d flags %b value %h",
						$time, received, field_o.tag, field_o.value_len,
						field_o[3:0], field_o.value);
					$display("  expected tag %h len %0d flags %b value %h",
						e.tag, e.value_len, e[3:0], e.value);
					errors++;
					test_errors++;
				end
			end
			received++;
		end
	end

	initial begin
		rst           = 1'b1;
		in_data_i     = 8'h00;
		in_valid_i    = 1'b0;
		field_ready_i = 1'b1;
		fill_table();
		repeat (10) tick();
		rst = 1'b0;
		for (int t = 1; t <= NUM_TESTS && !timed_out; t++) begin
			run_test(t);
		end
		repeat (20) tick(); // room for a stray extra record.
		$display("summary: %0d of %0d tests ok, %0d records checked, %0d errors",
			tests_passed, tests_run, received, errors);
		if (errors == 0 && !timed_out && tests_passed == NUM_TESTS) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* fix_parser_assert.sv */
// ######################################################################
// handshake and record flag properties, bound to fix_parser_top.
// ######################################################################

`timescale 1ns/1ns

module fix_parser_assert import fix_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic [7:0] in_data_i,
	input logic       in_valid_i,
	input logic       in_ready_o,
	input fix_field_t field_o,
	input logic       field_valid_o,
	input logic       field_ready_i
);

	in_data_held: assert property (@(posedge clk) disable iff (rst)
		in_valid_i && !in_ready_o |=> $stable(in_data_i))
		else $error("input byte changed while stalled");

	field_held: assert property (@(posedge clk) disable iff (rst)
		field_valid_o && !field_ready_i |=> $stable(field_o))
		else $error("output record changed while stalled");

	// pointers are cleared by the first reset edge.
	no_field_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !field_valid_o)
		else $error("record valid during reset");

	one_message_flag: assert property (@(posedge clk) disable iff (rst)
		field_valid_o |-> !(field_o.start_of_message && field_o.end_of_message))
		else $error("record marks both start and end of message");

endmodule

bind fix_parser_top fix_parser_assert u_assert (
	.clk           (clk),
	.rst           (rst),
	.in_data_i     (in_data_i),
	.in_valid_i    (in_valid_i),
	.in_ready_o    (in_ready_o),
	.field_o       (field_o),
	.field_valid_o (field_valid_o),
	.field_ready_i (field_ready_i)
);

/* fix_parser_top.sv */
// ######################################################################
// streaming FIX field parser, lexer, extractor and record FIFO.
// no checksum, body length or repeating group checks. back-pressure
// comes only from field_ready_i through the FIFO.
// ######################################################################

`timescale 1ns/1ns

module fix_parser_top import fix_pkg::*; #(
	parameter int MAX_VALUE_BYTES = FIELD_VALUE_BYTES, // 1..FIELD_VALUE_BYTES.
	parameter int FIFO_DEPTH      = 4                  // power of two, >= 2.
) (
	input  logic       clk,
	input  logic       rst,

	input  logic [7:0] in_data_i,
	input  logic       in_valid_i,
	output logic       in_ready_o,

	output fix_field_t field_o,
	output logic       field_valid_o,
	input  logic       field_ready_i
);

	fix_token_t tok;
	logic       tok_valid;
	logic       tok_ready;
	fix_field_t fld;
	logic       fld_valid;
	logic       fld_ready;

	fix_lexer u_lexer (
		.clk         (clk),
		.rst         (rst),
		.in_data_i   (in_data_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.tok_o       (tok),
		.tok_valid_o (tok_valid),
		.tok_ready_i (tok_ready)
	);

	fix_field_extract #(.MAX_VALUE_BYTES(MAX_VALUE_BYTES)) u_extract (
		.clk         (clk),
		.rst         (rst),
		.tok_i       (tok),
		.tok_valid_i (tok_valid),
		.tok_ready_o (tok_ready),
		.fld_o       (fld),
		.fld_valid_o (fld_valid),
		.fld_ready_i (fld_ready)
	);

	fix_field_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk        (clk),
		.rst        (rst),
		.wr_data_i  (fld),
		.wr_valid_i (fld_valid),
		.wr_ready_o (fld_ready),
		.rd_data_o  (field_o),
		.rd_valid_o (field_valid_o),
		.rd_ready_i (field_ready_i)
	);

endmodule

/* fix_field_fifo.sv */
// ######################################################################
// synchronous FIFO of field records, combinational read port.
// FIFO_DEPTH must be a power of two and at least 2. a full FIFO
// still takes a write in the cycle it is read.
// ######################################################################

`timescale 1ns/1ns

module fix_field_fifo import fix_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst,

	input  fix_field_t wr_data_i,
	input  logic       wr_valid_i,
	output logic       wr_ready_o,

	output fix_field_t rd_data_o,
	output logic       rd_valid_o,
	input  logic       rd_ready_i
);

	localparam int AW = $clog2(FIFO_DEPTH);

	fix_field_t  mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr; // extra bit tells full from empty.
	logic [AW:0] rd_ptr;
	logic        empty;
	logic        full;
	logic        wr_fire;
	logic        rd_fire;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign wr_ready_o = !full || rd_ready_i;
	assign rd_valid_o = !empty;
	assign rd_data_o  = mem[rd_ptr[AW-1:0]];

	assign wr_fire = wr_valid_i && wr_ready_o;
	assign rd_fire = rd_valid_o && rd_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// when full, the slot written is the one being read out now.
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr[AW-1:0]] <= wr_data_i;
		end
	end

endmodule

/* fix_field_extract.sv */
// ######################################################################
// field extractor, builds one record per FIX field from lexer tokens.
// MAX_VALUE_BYTES must lie in 1..FIELD_VALUE_BYTES. tags keep their
// first four bytes; values keep their first MAX_VALUE_BYTES bytes.
// the token input stalls while a finished record waits for ready.
// ######################################################################

`timescale 1ns/1ns

module fix_field_extract import fix_pkg::*; #(
	parameter int MAX_VALUE_BYTES = FIELD_VALUE_BYTES
) (
	input  logic       clk,
	input  logic       rst,

	input  fix_token_t tok_i,
	input  logic       tok_valid_i,
	output logic       tok_ready_o,

	output fix_field_t fld_o,
	output logic       fld_valid_o,
	input  logic       fld_ready_i
);

	localparam int         VAL_W   = MAX_VALUE_BYTES * 8;
	localparam logic [7:0] MAX_LEN = 8'(MAX_VALUE_BYTES);

	typedef enum logic [1:0] {
		ST_TAG   = 2'd0,
		ST_VALUE = 2'd1,
		ST_HOLD  = 2'd2
	} state_e;

	state_e           state;
	logic [31:0]      tag_q;
	logic [2:0]       tag_cnt; // stored tag bytes, 0..4.
	logic [VAL_W-1:0] val_q;
	logic [7:0]       val_len;
	logic             ovf;
	logic             tok_fire;
	logic             field_done;
	fix_field_t       rec;
	fix_field_t       fld_q;

	assign tok_ready_o = (state != ST_HOLD);
	assign tok_fire    = tok_valid_i && tok_ready_o;
	assign field_done  = tok_fire && (tok_i.kind == TOK_VAL_END);
	assign fld_valid_o = (state == ST_HOLD);
	assign fld_o       = fld_q;

	// the record as it stands when the closing SOH arrives.
	always_comb begin
		rec                  = '0;
		rec.tag              = tag_q;
		rec.value[VAL_W-1:0] = val_q;
		rec.value_len        = val_len;
		rec.start_of_message = (tag_q == {24'h000000, TAG_BEGIN_STRING});
		rec.end_of_message   = (tag_q == {16'h0000, TAG_CHECKSUM});
		rec.overflow         = ovf;
		rec.malformed        = (state == ST_TAG); // SOH came before any '='.
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= ST_TAG;
			tag_q   <= '0;
			tag_cnt <= '0;
			val_q   <= '0;
			val_len <= '0;
			ovf     <= 1'b0;
		end else if (field_done) begin
			// clear the accumulators, the record is captured below.
			state   <= ST_HOLD;
			tag_q   <= '0;
			tag_cnt <= '0;
			val_q   <= '0;
			val_len <= '0;
			ovf     <= 1'b0;
		end else begin
			case (state)
				ST_TAG: begin
					if (tok_fire && tok_i.kind == TOK_TAG_BYTE) begin
						if (tag_cnt < 3'd4) begin
							tag_q   <= {tag_q[23:0], tok_i.data};
							tag_cnt <= tag_cnt + 3'd1;
						end else begin
							ovf <= 1'b1; // fifth tag byte is dropped.
						end
					end else if (tok_fire && tok_i.kind == TOK_TAG_END) begin
						state <= ST_VALUE;
					end
				end
				ST_VALUE: begin
					if (tok_fire && tok_i.kind == TOK_VAL_BYTE) begin
						if (val_len < MAX_LEN) begin
							val_q <= (val_q << 8) | VAL_W'(tok_i.data);
						end else begin
							ovf <= 1'b1; // counted, not stored.
						end
						if (val_len != 8'hff) begin
							val_len <= val_len + 8'd1;
						end
					end
				end
				ST_HOLD: begin
					if (fld_ready_i) begin
						state <= ST_TAG;
					end
				end
				default: state <= ST_TAG;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (field_done) begin
			fld_q <= rec;
		end
	end

endmodule

/* fix_lexer.sv */
// ######################################################################
// byte lexer, splits a FIX stream into tag and value tokens.
// one token register; an SOH in tag mode is sent on as a value end
// so that the extractor can flag the field as malformed.
// ######################################################################

`timescale 1ns/1ns

module fix_lexer import fix_pkg::*; (
	input  logic       clk,
	input  logic       rst,

	input  logic [7:0] in_data_i,
	input  logic       in_valid_i,
	output logic       in_ready_o,

	output fix_token_t tok_o,
	output logic       tok_valid_o,
	input  logic       tok_ready_i
);

	logic       in_value;    // 0 while reading a tag, 1 while reading a value.
	logic       in_fire;
	logic       tok_valid_q;
	fix_token_t tok_q;
	fix_token_t tok_next;

	// free slot, or the held token leaves this cycle.
	assign in_ready_o  = !tok_valid_q || tok_ready_i;
	assign in_fire     = in_valid_i && in_ready_o;
	assign tok_o       = tok_q;
	assign tok_valid_o = tok_valid_q;

	// classify the incoming byte against the current mode.
	always_comb begin
		tok_next.data = in_data_i;
		if (in_data_i == FIX_SOH) begin
			tok_next.kind = TOK_VAL_END;
			tok_next.data = 8'h00;
		end else if (!in_value && in_data_i == FIX_EQ) begin
			tok_next.kind = TOK_TAG_END;
			tok_next.data = 8'h00;
		end else if (in_value) begin
			tok_next.kind = TOK_VAL_BYTE; // '=' inside a value is plain data.
		end else begin
			tok_next.kind = TOK_TAG_BYTE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			in_value    <= 1'b0;
			tok_valid_q <= 1'b0;
		end else begin
			if (in_fire) begin
				tok_valid_q <= 1'b1;
			end else if (tok_ready_i) begin
				tok_valid_q <= 1'b0;
			end

			if (in_fire) begin
				if (tok_next.kind == TOK_TAG_END) begin
					in_value <= 1'b1;
				end else if (tok_next.kind == TOK_VAL_END) begin
					in_value <= 1'b0; // a stray SOH in a tag keeps tag mode.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			tok_q <= tok_next;
		end
	end

endmodule

/* fix_pkg.sv */
// ######################################################################
// shared types and character constants of the FIX field parser.
// records carry at most FIELD_VALUE_BYTES value bytes; a smaller
// MAX_VALUE_BYTES in the design only truncates earlier.
// ######################################################################

package fix_pkg;

	localparam int FIELD_VALUE_BYTES = 16; // widest value a record holds.

	localparam logic [7:0]  FIX_SOH          = 8'h01;
	localparam logic [7:0]  FIX_EQ           = 8'h3d;   // '='.
	localparam logic [7:0]  TAG_BEGIN_STRING = 8'h38;   // "8".
	localparam logic [15:0] TAG_CHECKSUM     = 16'h3130; // "10".

	// what a lexer token carries.
	typedef enum logic [1:0] {
		TOK_TAG_BYTE = 2'd0,
		TOK_VAL_BYTE = 2'd1,
		TOK_TAG_END  = 2'd2, // '=' seen in tag mode.
		TOK_VAL_END  = 2'd3  // SOH seen, in either mode.
	} fix_tok_kind_e;

	typedef struct packed {
		fix_tok_kind_e kind;
		logic [7:0]    data; // zero on end tokens.
	} fix_token_t;

	// one parsed field, tag and value right-aligned ASCII.
	typedef struct packed {
		logic [31:0]                    tag;
		logic [FIELD_VALUE_BYTES*8-1:0] value;
		logic [7:0]                     value_len; // saturates at 255.
		logic                           start_of_message;
		logic                           end_of_message;
		logic                           overflow;
		logic                           malformed;
	} fix_field_t;

endpackage
